// ==== project.f ====
src/proc_pkg.sv
src/pipe_reg.sv
src/fetch.sv
src/regfile.sv
src/decode.sv
src/execute.sv
src/memory.sv
src/hazard_unit.sv
src/proc.sv
test/proc_tb.sv

// ==== src/decode.sv ====
// Instruction decode
`timescale 1ns/1ns
`default_nettype none

module decode import proc_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire if_id_t      in_if,
    input  wire logic        wb_we,
    input  wire logic [4:0]  wb_rd,
    input  wire logic [31:0] wb_data,
    output id_ex_t           out_id,
    output logic      [4:0]  rs1,
    output logic      [4:0]  rs2
);

    logic [31:0] instr;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm;
    ctrl_t       ctrl;

    assign instr  = in_if.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    regfile u_regfile (
        .clk (clk),
        .rst (rst),
        .ra1 (rs1),
        .ra2 (rs2),
        .rd1 (rs1_data),
        .rd2 (rs2_data),
        .we  (wb_we),
        .wa  (wb_rd),
        .wd  (wb_data)
    );

    // Anything unrecognised falls through as a no-op
    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            OP_R: begin
                ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrl.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: ctrl.alu_op = ALU_SUB;
                    {7'h00, 3'b111}: ctrl.alu_op = ALU_AND;
                    {7'h00, 3'b110}: ctrl.alu_op = ALU_OR;
                    {7'h00, 3'b100}: ctrl.alu_op = ALU_XOR;
                    {7'h00, 3'b010}: ctrl.alu_op = ALU_SLT;
                    default:         ctrl.reg_write = 1'b0;
                endcase
            end
            OP_IMM: begin
                imm              = {{20{instr[31]}}, instr[31:20]};
                ctrl.reg_write   = (funct3 == 3'b000);
                ctrl.alu_src_imm = 1'b1;
            end
            OP_LOAD: begin
                imm              = {{20{instr[31]}}, instr[31:20]};
                ctrl.reg_write   = (funct3 == 3'b010);
                ctrl.mem_read    = (funct3 == 3'b010);
                ctrl.alu_src_imm = 1'b1;
                ctrl.res_sel     = RES_MEM;
            end
            OP_STORE: begin
                imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                ctrl.mem_write   = (funct3 == 3'b010);
                ctrl.alu_src_imm = 1'b1;
            end
            OP_BRANCH: begin
                imm            = {{19{instr[31]}}, instr[31], instr[7],
                                  instr[30:25], instr[11:8], 1'b0};
                ctrl.branch    = (funct3 == 3'b000) || (funct3 == 3'b001);
                ctrl.branch_ne = (funct3 == 3'b001);
            end
            OP_JAL: begin
                imm              = {{11{instr[31]}}, instr[31], instr[19:12],
                                    instr[20], instr[30:21], 1'b0};
                ctrl.reg_write   = 1'b1;
                ctrl.jump        = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_PASSB;
                ctrl.res_sel     = RES_PC4;
            end
            default: ;
        endcase
    end

    assign out_id = '{valid: in_if.valid, pc: in_if.pc, ctrl: ctrl,
                      rs1: rs1, rs2: rs2, rs1_data: rs1_data, rs2_data: rs2_data,
                      rd: instr[11:7], imm: imm};

endmodule

`default_nettype wire

// ==== src/execute.sv ====
// Execute stage
`timescale 1ns/1ns
`default_nettype none

module execute import proc_pkg::*; (
    input  wire id_ex_t      in_id,
    input  wire fwd_sel_e    fwd_a,
    input  wire fwd_sel_e    fwd_b,
    input  wire logic [31:0] mem_fwd,
    input  wire logic [31:0] wb_fwd,
    output ex_mem_t          out_ex,
    output logic             redirect,
    output logic      [31:0] redirect_pc
);

    logic [31:0] op_a;
    logic [31:0] rs2_val;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic        equal;
    logic        taken;

    // Operand forwarding
    always_comb begin
        case (fwd_a)
            FWD_MEM: op_a = mem_fwd;
            FWD_WB:  op_a = wb_fwd;
            default: op_a = in_id.rs1_data;
        endcase
        case (fwd_b)
            FWD_MEM: rs2_val = mem_fwd;
            FWD_WB:  rs2_val = wb_fwd;
            default: rs2_val = in_id.rs2_data;
        endcase
    end

    assign op_b = in_id.ctrl.alu_src_imm ? in_id.imm : rs2_val;

    always_comb begin
        case (in_id.ctrl.alu_op)
            ALU_SUB:   alu_result = op_a - op_b;
            ALU_AND:   alu_result = op_a & op_b;
            ALU_OR:    alu_result = op_a | op_b;
            ALU_XOR:   alu_result = op_a ^ op_b;
            ALU_SLT:   alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_PASSB: alu_result = op_b;
            default:   alu_result = op_a + op_b;
        endcase
    end

    // Branch compare uses the register operand, never the immediate
    assign equal       = (op_a == rs2_val);
    assign taken       = in_id.ctrl.branch && (in_id.ctrl.branch_ne ? !equal : equal);
    assign redirect    = in_id.valid && (taken || in_id.ctrl.jump);
    assign redirect_pc = in_id.pc + in_id.imm;

    assign out_ex = '{valid: in_id.valid, pc_plus4: in_id.pc + 32'd4,
                      reg_write: in_id.ctrl.reg_write, mem_read: in_id.ctrl.mem_read,
                      mem_write: in_id.ctrl.mem_write, res_sel: in_id.ctrl.res_sel,
                      rd: in_id.rd, alu_result: alu_result, store_data: rs2_val};

endmodule

`default_nettype wire

// ==== src/fetch.sv ====
// Instruction fetch
`timescale 1ns/1ns
`default_nettype none

module fetch import proc_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        stall,
    input  wire logic        redirect,
    input  wire logic [31:0] redirect_pc,
    output logic      [31:0] imem_addr,
    input  wire logic [31:0] imem_data,
    output if_id_t           out_if
);

    logic [31:0] pc;

    // Redirect overrides a load-use hold
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign imem_addr = pc;
    assign out_if    = '{valid: 1'b1, pc: pc, instr: imem_data};

endmodule

`default_nettype wire

// ==== src/hazard_unit.sv ====
// Forwarding and hazard control
`timescale 1ns/1ns
`default_nettype none

module hazard_unit import proc_pkg::*; (
    input  wire logic [4:0] rs1_d,
    input  wire logic [4:0] rs2_d,
    input  wire logic [4:0] rs1_e,
    input  wire logic [4:0] rs2_e,
    input  wire logic [4:0] rd_e,
    input  wire logic       mem_read_e,
    input  wire logic [4:0] rd_m,
    input  wire logic       reg_write_m,
    input  wire logic [4:0] rd_w,
    input  wire logic       reg_write_w,
    input  wire logic       redirect,
    output logic            stall_f,
    output logic            stall_d,
    output logic            flush_d,
    output logic            flush_e,
    output fwd_sel_e        fwd_a,
    output fwd_sel_e        fwd_b
);

    logic load_use;

    // Youngest producer wins
    assign fwd_a = (reg_write_m && rd_m != 5'd0 && rd_m == rs1_e) ? FWD_MEM :
                   (reg_write_w && rd_w != 5'd0 && rd_w == rs1_e) ? FWD_WB : FWD_RF;
    assign fwd_b = (reg_write_m && rd_m != 5'd0 && rd_m == rs2_e) ? FWD_MEM :
                   (reg_write_w && rd_w != 5'd0 && rd_w == rs2_e) ? FWD_WB : FWD_RF;

    assign load_use = mem_read_e && rd_e != 5'd0 && (rd_e == rs1_d || rd_e == rs2_d);

    assign stall_f = load_use;
    assign stall_d = load_use;
    assign flush_d = redirect;
    // Bubble into execute for either case
    assign flush_e = redirect || load_use;

endmodule

`default_nettype wire

// ==== src/memory.sv ====
// Data memory stage
`timescale 1ns/1ns
`default_nettype none

module memory import proc_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire ex_mem_t in_ex,
    output mem_wb_t      out_mem
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [31:0]   ram [0:DMEM_WORDS-1];
    logic [AW-1:0] word_addr;

    assign word_addr = in_ex.alu_result[AW+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                ram[i] <= '0;
            end
        end else if (in_ex.valid && in_ex.mem_write) begin
            ram[word_addr] <= in_ex.store_data;
        end
    end

    assign out_mem = '{valid: in_ex.valid, pc_plus4: in_ex.pc_plus4,
                       reg_write: in_ex.reg_write, res_sel: in_ex.res_sel, rd: in_ex.rd,
                       alu_result: in_ex.alu_result, mem_data: ram[word_addr]};

    a_aligned: assert property (@(posedge clk) disable iff (rst)
        (in_ex.valid && (in_ex.mem_read || in_ex.mem_write)) |-> in_ex.alu_result[1:0] == 2'b00)
        else $error("memory: misaligned access at %h", in_ex.alu_result);

endmodule

`default_nettype wire

// ==== src/pipe_reg.sv ====
// Pipeline stage register
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
    parameter type T = logic [0:0]
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic stall,
    input  wire logic flush,
    input  wire T     d,
    output T          q
);

    // Flush beats stall
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

    a_q_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(q))
        else $error("pipe_reg: unknown payload");

endmodule

`default_nettype wire

// ==== src/proc.sv ====
// Five-stage RV32I core
`timescale 1ns/1ns
`default_nettype none

module proc import proc_pkg::*; #(
    parameter logic [31:0] RESET_PC   = 32'h0000_0000,
    parameter int          DMEM_WORDS = 256
) (
    input  wire logic        clk,
    input  wire logic        rst,
    output logic      [31:0] imem_addr,
    input  wire logic [31:0] imem_data,
    output logic             retire_valid,
    output logic      [4:0]  retire_rd,
    output logic      [31:0] retire_data
);

    if_id_t   if_id_d, if_id_q;
    id_ex_t   id_ex_d, id_ex_q;
    ex_mem_t  ex_mem_d, ex_mem_q;
    mem_wb_t  mem_wb_d, mem_wb_q;

    logic        stall_f, stall_d, flush_d, flush_e;
    fwd_sel_e    fwd_a, fwd_b;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic [4:0]  rs1_d, rs2_d;
    logic [31:0] mem_fwd;
    logic [31:0] wb_data;
    logic        wb_we;

    fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall_f),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .out_if      (if_id_d)
    );

    pipe_reg #(.T(if_id_t)) if_id (
        .clk(clk), .rst(rst), .stall(stall_d), .flush(flush_d), .d(if_id_d), .q(if_id_q)
    );

    decode u_decode (
        .clk     (clk),
        .rst     (rst),
        .in_if   (if_id_q),
        .wb_we   (wb_we),
        .wb_rd   (mem_wb_q.rd),
        .wb_data (wb_data),
        .out_id  (id_ex_d),
        .rs1     (rs1_d),
        .rs2     (rs2_d)
    );

    pipe_reg #(.T(id_ex_t)) id_ex (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(flush_e), .d(id_ex_d), .q(id_ex_q)
    );

    // JAL in memory stage forwards its link value
    assign mem_fwd = (ex_mem_q.res_sel == RES_PC4) ? ex_mem_q.pc_plus4 : ex_mem_q.alu_result;

    execute u_execute (
        .in_id       (id_ex_q),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_data),
        .out_ex      (ex_mem_d),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    pipe_reg #(.T(ex_mem_t)) ex_mem (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q)
    );

    memory #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
        .clk     (clk),
        .rst     (rst),
        .in_ex   (ex_mem_q),
        .out_mem (mem_wb_d)
    );

    pipe_reg #(.T(mem_wb_t)) mem_wb (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
    );

    hazard_unit u_hazard (
        .rs1_d       (rs1_d),
        .rs2_d       (rs2_d),
        .rs1_e       (id_ex_q.rs1),
        .rs2_e       (id_ex_q.rs2),
        .rd_e        (id_ex_q.rd),
        .mem_read_e  (id_ex_q.ctrl.mem_read),
        .rd_m        (ex_mem_q.rd),
        .reg_write_m (ex_mem_q.reg_write),
        .rd_w        (mem_wb_q.rd),
        .reg_write_w (mem_wb_q.reg_write),
        .redirect    (redirect),
        .stall_f     (stall_f),
        .stall_d     (stall_d),
        .flush_d     (flush_d),
        .flush_e     (flush_e),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b)
    );

    // Writeback select
    always_comb begin
        case (mem_wb_q.res_sel)
            RES_MEM: wb_data = mem_wb_q.mem_data;
            RES_PC4: wb_data = mem_wb_q.pc_plus4;
            default: wb_data = mem_wb_q.alu_result;
        endcase
    end

    assign wb_we        = mem_wb_q.valid && mem_wb_q.reg_write;
    assign retire_valid = wb_we;
    assign retire_rd    = mem_wb_q.rd;
    assign retire_data  = wb_data;

endmodule

`default_nettype wire

// ==== src/proc_pkg.sv ====
// Pipeline shared types
`default_nettype none

package proc_pkg;

    // Major opcodes
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } res_sel_e;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        logic     branch_ne;
        logic     jump;
        logic     alu_src_imm;
        alu_op_e  alu_op;
        res_sel_e res_sel;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        ctrl_t       ctrl;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [4:0]  rd;
        logic [31:0] imm;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc_plus4;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        res_sel_e    res_sel;
        logic [4:0]  rd;
        logic [31:0] alu_result;
        logic [31:0] store_data;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc_plus4;
        logic        reg_write;
        res_sel_e    res_sel;
        logic [4:0]  rd;
        logic [31:0] alu_result;
        logic [31:0] mem_data;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== src/regfile.sv ====
// Integer register file
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [4:0]  ra1,
    input  wire logic [4:0]  ra2,
    output logic      [31:0] rd1,
    output logic      [31:0] rd2,
    input  wire logic        we,
    input  wire logic [4:0]  wa,
    input  wire logic [31:0] wd
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle writeback bypass
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : (we && wa == ra2) ? wd : regs[ra2];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == 32'd0)
        else $error("regfile: x0 holds %h", regs[0]);

endmodule

`default_nettype wire

// ==== test/proc_tb.sv ====
// Pipelined core testbench
`timescale 1ns/1ns
`default_nettype none

module proc_tb;

    localparam int ROM_WORDS = 128;
    localparam int DMEM_WORDS = 256;
    localparam int MAX_EXP = 128;
    localparam int RANDOM_OPS = 32;

    logic        clk;
    logic        rst;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    logic [31:0] rom [0:ROM_WORDS-1];
    int          prog_len;
    logic [4:0]  exp_rd [0:MAX_EXP-1];
    logic [31:0] exp_data [0:MAX_EXP-1];
    int          exp_count;
    int          ret_idx = 0;
    int          mismatches;
    int          timed_out;
    int          cycles;
    int          limit;
    logic [31:0] lfsr_state;

    proc #(.RESET_PC(32'h0000_0000), .DMEM_WORDS(DMEM_WORDS)) DUT (
        .clk          (clk),
        .rst          (rst),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #4 clk = ~clk;

    // Past the program the ROM reads as zero, which decodes to a no-op
    assign imem_data = (imem_addr[31:2] < ROM_WORDS) ? rom[imem_addr[31:2]] : 32'h0;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, (op == 7'b0000011) ? 3'b010 : 3'b000, rd, op};
    endfunction

    // sw rs2, imm(rs1)
    function automatic logic [31:0] s_type(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function void emit(input logic [31:0] instr);
        rom[prog_len] = instr;
        prog_len++;
    endfunction

    function void add_random_alu();
        logic [2:0]  sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        sel = rand_bits(3);
        rd  = rand_bits(5);
        rs1 = rand_bits(5);
        rs2 = rand_bits(5);
        imm = rand_bits(12);
        case (sel)
            3'd0:    emit(r_type(7'h00, 3'd0, rd, rs1, rs2));
            3'd1:    emit(r_type(7'h20, 3'd0, rd, rs1, rs2));
            3'd2:    emit(r_type(7'h00, 3'd7, rd, rs1, rs2));
            3'd3:    emit(r_type(7'h00, 3'd6, rd, rs1, rs2));
            3'd4:    emit(r_type(7'h00, 3'd4, rd, rs1, rs2));
            3'd5:    emit(r_type(7'h00, 3'd2, rd, rs1, rs2));
            default: emit(i_type(7'b0010011, rd, rs1, imm));
        endcase
    endfunction

    task automatic build_program();
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = 32'h0;
        end
        prog_len = 0;
        emit(i_type(7'b0010011, 5'd1, 5'd0, 12'd100));
        emit(i_type(7'b0010011, 5'd2, 5'd0, -12'sd7));
        // Dependent chain through both forwarding paths
        emit(r_type(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
        emit(r_type(7'h20, 3'd0, 5'd4, 5'd3, 5'd1));
        emit(r_type(7'h00, 3'd7, 5'd5, 5'd4, 5'd3));
        emit(r_type(7'h00, 3'd6, 5'd6, 5'd5, 5'd2));
        emit(r_type(7'h00, 3'd4, 5'd7, 5'd6, 5'd1));
        emit(r_type(7'h00, 3'd2, 5'd8, 5'd2, 5'd1));
        emit(r_type(7'h00, 3'd2, 5'd9, 5'd1, 5'd2));
        // Store then load-use on rs2 and on rs1
        emit(s_type(5'd0, 5'd3, 12'd8));
        emit(i_type(7'b0000011, 5'd10, 5'd0, 12'd8));
        emit(r_type(7'h00, 3'd0, 5'd11, 5'd1, 5'd10));
        emit(s_type(5'd0, 5'd11, 12'd16));
        emit(i_type(7'b0000011, 5'd12, 5'd0, 12'd16));
        emit(i_type(7'b0010011, 5'd12, 5'd12, 12'd1));
        emit(i_type(7'b0010011, 5'd22, 5'd0, 12'd100));
        emit(b_type(3'd0, 5'd22, 5'd1, 13'd12));
        emit(i_type(7'b0010011, 5'd13, 5'd0, 12'd1));
        emit(i_type(7'b0010011, 5'd14, 5'd0, 12'd2));
        emit(b_type(3'd1, 5'd1, 5'd1, 13'd8));
        emit(i_type(7'b0010011, 5'd15, 5'd0, 12'd3));
        emit(b_type(3'd0, 5'd1, 5'd2, 13'd8));
        emit(i_type(7'b0010011, 5'd21, 5'd0, 12'd6));
        emit(b_type(3'd1, 5'd1, 5'd2, 13'd8));
        emit(i_type(7'b0010011, 5'd16, 5'd0, 12'd4));
        emit(j_type(5'd17, 21'd12));
        emit(i_type(7'b0010011, 5'd18, 5'd0, 12'd5));
        emit(i_type(7'b0010011, 5'd19, 5'd0, 12'd5));
        // x0 as destination, then as a source
        emit(i_type(7'b0010011, 5'd0, 5'd1, 12'd55));
        emit(r_type(7'h00, 3'd0, 5'd20, 5'd0, 5'd1));
        for (int i = 0; i < RANDOM_OPS; i++) begin
            add_random_alu();
        end
    endtask

    function void push_expected(input logic [4:0] rd, input logic [31:0] value);
        exp_rd[exp_count]   = rd;
        exp_data[exp_count] = value;
        exp_count++;
    endfunction

    // Sequential instruction-set model over the same ROM
    task automatic run_model();
        logic [31:0] regs [0:31];
        logic [31:0] dmem [0:DMEM_WORDS-1];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic        writes;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = '0;
        end
        exp_count = 0;
        pc = '0;
        steps = 0;
        while (pc < prog_len * 4 && steps < 4 * ROM_WORDS) begin
            ins     = rom[pc[31:2]];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            next_pc = pc + 4;
            writes  = 1'b0;
            res     = '0;
            case (ins[6:0])
                7'b0110011: begin
                    writes = 1'b1;
                    case ({ins[31:25], ins[14:12]})
                        {7'h00, 3'd0}: res = a + b;
                        {7'h20, 3'd0}: res = a - b;
                        {7'h00, 3'd7}: res = a & b;
                        {7'h00, 3'd6}: res = a | b;
                        {7'h00, 3'd4}: res = a ^ b;
                        {7'h00, 3'd2}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:       writes = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    writes = (ins[14:12] == 3'd0);
                    res    = a + imm_i;
                end
                7'b0000011: begin
                    writes = (ins[14:12] == 3'd2);
                    res    = dmem[(a + imm_i) >> 2];
                end
                7'b0100011: begin
                    if (ins[14:12] == 3'd2) begin
                        dmem[(a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) >> 2] = b;
                    end
                end
                7'b1100011: begin
                    if ((ins[14:12] == 3'd0 && a == b) || (ins[14:12] == 3'd1 && a != b)) begin
                        next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                    end
                end
                7'b1101111: begin
                    writes  = 1'b1;
                    res     = pc + 4;
                    next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
                end
                default: ;
            endcase
            if (writes) begin
                push_expected(ins[11:7], res);
                if (ins[11:7] != 5'd0) begin
                    regs[ins[11:7]] = res;
                end
            end
            pc = next_pc;
            steps++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            ret_idx <= 0;
        end else if (retire_valid) begin
            ret_idx <= ret_idx + 1;
        end
    end

    a_retire_match: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> (ret_idx < exp_count && retire_rd == exp_rd[ret_idx]
                          && retire_data == exp_data[ret_idx]))
        else begin
            mismatches++;
            $display("error %0t: retired rd %0d data %h, expected rd %0d data %h (result %0d)",
                     $time, $sampled(retire_rd), $sampled(retire_data),
                     exp_rd[$sampled(ret_idx)], exp_data[$sampled(ret_idx)],
                     $sampled(ret_idx));
        end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        mismatches = 0;
        timed_out = 0;
        cycles = 0;
        lfsr_state = 32'h407c_f688;
        build_program();
        run_model();
        limit = 5 * prog_len + 100;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        while (ret_idx < exp_count && cycles < limit) begin
            @(posedge clk);
            #1 cycles++;
        end
        if (ret_idx < exp_count) begin
            timed_out = 1;
            $display("The pipeline stopped retiring: %0d of %0d results after %0d cycles",
                     ret_idx, exp_count, cycles);
        end else begin
            // Catch anything retiring after the last expected result
            repeat (10) @(posedge clk);
        end
        $display("Summary: %0d retire mismatches, %0d timeouts", mismatches, timed_out);
        if (mismatches == 0 && timed_out == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
